// File: rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int INSTR_W = 32;
    localparam int PC_STEP = 4;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;

    // Major opcodes
    // OPCODE_UNKNOWN stands for anything not decoded
    typedef enum logic [6:0] {
        OPCODE_UNKNOWN = 7'b0000000,
        OPCODE_OP_IMM  = 7'b0010011,
        OPCODE_OP      = 7'b0110011,
        OPCODE_JAL     = 7'b1101111,
        OPCODE_JALR    = 7'b1100111,
        OPCODE_LUI     = 7'b0110111,
        OPCODE_AUIPC   = 7'b0010111,
        OPCODE_BRANCH  = 7'b1100011,
        OPCODE_LOAD    = 7'b0000011,
        OPCODE_STORE   = 7'b0100011,
        OPCODE_SYSTEM  = 7'b1110011,
        OPCODE_FENCE   = 7'b0001111
    } opcode_e;

    // Integer function codes
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // Branch function codes
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [31:0] {
        EXC_ILLEGAL_INSTR      = 32'd2,
        EXC_LOAD_MISALIGNED    = 32'd4,
        EXC_LOAD_ACCESS_FAULT  = 32'd5,
        EXC_STORE_MISALIGNED   = 32'd6,
        EXC_STORE_ACCESS_FAULT = 32'd7,
        EXC_LOAD_PAGE_FAULT    = 32'd13,
        EXC_STORE_PAGE_FAULT   = 32'd15
    } exc_cause_e;

endpackage

// File: exec_pkg.sv
package exec_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [3:0] {
        CMD_NONE  = 4'd0,
        CMD_LOAD  = 4'd2,
        CMD_STORE = 4'd3
    } cache_cmd_e;

    typedef enum logic [3:0] {
        RESP_IDLE        = 4'd0,
        RESP_WAIT        = 4'd1,
        RESP_DONE        = 4'd2,
        RESP_ACCESSFAULT = 4'd3,
        RESP_PAGEFAULT   = 4'd4,
        RESP_MISALIGNED  = 4'd5
    } cache_resp_e;

    // Write-back source
    typedef enum logic [2:0] {
        RD_ALU       = 3'd0,
        RD_LOAD      = 3'd2,
        RD_LUI       = 3'd3,
        RD_AUIPC     = 3'd4,
        RD_PC_PLUS_4 = 3'd5
    } rd_sel_e;

    typedef struct packed {
        logic [INSTR_W-1:0] instr;
        xlen_t              pc;
    } fetch_in_t;

    typedef struct packed {
        logic  ready;
        logic  exc_start;
        logic  branch_taken;
        xlen_t branch_target;
    } fetch_out_t;

    typedef struct packed {
        cache_cmd_e cmd;
        xlen_t      address;
        funct3_t    load_type;
        logic [1:0] store_type;
        xlen_t      store_data;
    } cache_req_t;

    typedef struct packed {
        cache_resp_e response;
        xlen_t       load_data;
    } cache_rsp_t;

    typedef struct packed {
        logic      write;
        reg_addr_t addr;
        xlen_t     wdata;
    } rd_write_t;

    typedef struct packed {
        logic       valid;
        exc_cause_e cause;
        xlen_t      epc;
    } exc_report_t;

    // Fields and immediates of the instruction in execute
    typedef struct packed {
        opcode_e    opcode;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        funct3_t    funct3;
        logic [6:0] funct7;
        logic [4:0] shamt;
        xlen_t      imm_i;
        xlen_t      imm_s;
        xlen_t      imm_b;
        xlen_t      imm_u;
        xlen_t      imm_j;
    } decoded_t;

endpackage

// File: exec_decode.sv
`timescale 1ns/1ps

module exec_decode (
    input  rv_isa_pkg::xlen_t   instr,
    output exec_pkg::decoded_t  dec
);

    import rv_isa_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        // Anything outside the supported set is reported as unknown
        case (instr[6:0])
            OPCODE_OP_IMM,
            OPCODE_OP,
            OPCODE_JAL,
            OPCODE_JALR,
            OPCODE_LUI,
            OPCODE_AUIPC,
            OPCODE_BRANCH,
            OPCODE_LOAD,
            OPCODE_STORE,
            OPCODE_SYSTEM,
            OPCODE_FENCE: begin
                dec.opcode = opcode_e'(instr[6:0]);
            end
            default: begin
                dec.opcode = OPCODE_UNKNOWN;
            end
        endcase

        dec.rd     = instr[11:7];
        dec.funct3 = instr[14:12];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.funct7 = instr[31:25];
        dec.shamt  = instr[24:20];

        // Sign-extended immediates
        dec.imm_i = {{20{sign}}, instr[31:20]};
        dec.imm_s = {{20{sign}}, instr[31:25], instr[11:7]};
        dec.imm_b = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        dec.imm_u = {instr[31:12], 12'h000};
        dec.imm_j = {{12{sign}}, instr[19:12], instr[20], instr[30:25], instr[24:21], 1'b0};
    end

endmodule

// File: exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
    input  exec_pkg::decoded_t  dec,
    input  rv_isa_pkg::xlen_t   rs1_data,
    input  rv_isa_pkg::xlen_t   rs2_data,
    output rv_isa_pkg::xlen_t   result,
    output logic                illegal
);

    import rv_isa_pkg::*;

    logic       is_op;
    logic       is_op_imm;
    logic       alt;
    xlen_t      operand_b;
    logic [4:0] shift;

    assign is_op     = (dec.opcode == OPCODE_OP);
    assign is_op_imm = (dec.opcode == OPCODE_OP_IMM);
    assign alt       = (dec.funct7 == F7_ALT);

    // Immediate form takes imm_i and the shamt field
    assign operand_b = is_op_imm ? dec.imm_i : rs2_data;
    assign shift     = is_op_imm ? dec.shamt : rs2_data[4:0];

    always_comb begin
        case (dec.funct3)
            F3_ADD_SUB: result = (is_op && alt) ? rs1_data - operand_b : rs1_data + operand_b;
            F3_SLL:     result = rs1_data << shift;
            F3_SLT:     result = {31'b0, $signed(rs1_data) < $signed(operand_b)};
            F3_SLTU:    result = {31'b0, rs1_data < operand_b};
            F3_XOR:     result = rs1_data ^ operand_b;
            F3_SRL_SRA: result = alt ? xlen_t'($signed(rs1_data) >>> shift) : rs1_data >> shift;
            F3_OR:      result = rs1_data | operand_b;
            default:    result = rs1_data & operand_b;
        endcase
    end

    always_comb begin
        illegal = 1'b0;
        if (is_op) begin
            // Only SUB and SRA accept the alternate funct7
            illegal = !((dec.funct7 == F7_BASE) ||
                        (alt && (dec.funct3 == F3_ADD_SUB || dec.funct3 == F3_SRL_SRA)));
        end else if (is_op_imm) begin
            if (dec.funct3 == F3_SLL) begin
                illegal = (dec.funct7 != F7_BASE);
            end else if (dec.funct3 == F3_SRL_SRA) begin
                illegal = !((dec.funct7 == F7_BASE) || alt);
            end
        end
    end

endmodule

// File: exec_branch_cond.sv
`timescale 1ns/1ps

module exec_branch_cond (
    input  rv_isa_pkg::funct3_t funct3,
    input  rv_isa_pkg::xlen_t   rs1_data,
    input  rv_isa_pkg::xlen_t   rs2_data,
    output logic                taken,
    output logic                illegal
);

    import rv_isa_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = (rs1_data == rs2_data);
    assign lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign ltu = (rs1_data < rs2_data);

    always_comb begin
        illegal = 1'b0;
        case (funct3)
            F3_BEQ:  taken = eq;
            F3_BNE:  taken = !eq;
            F3_BLT:  taken = lt;
            F3_BGE:  taken = !lt;
            F3_BLTU: taken = ltu;
            F3_BGEU: taken = !ltu;
            // funct3 010 and 011 are not branches
            default: begin
                taken   = 1'b0;
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: exec_mem_seq.sv
`timescale 1ns/1ps

module exec_mem_seq (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cache_reset_done,
    input  exec_pkg::decoded_t      dec,
    input  rv_isa_pkg::xlen_t       rs1_data,
    input  rv_isa_pkg::xlen_t       rs2_data,
    output exec_pkg::cache_req_t    req,
    input  exec_pkg::cache_rsp_t    rsp,
    output logic                    mem_done,
    output logic                    mem_err,
    output rv_isa_pkg::exc_cause_e  err_cause
);

    import rv_isa_pkg::*;
    import exec_pkg::*;

    logic issued;
    logic store_kind;
    logic do_load;
    logic do_store;
    logic rsp_done;
    logic rsp_err;

    assign store_kind = (dec.opcode == OPCODE_STORE);
    assign do_load    = (dec.opcode == OPCODE_LOAD);
    // Stores with funct3 bit 2 set never reach the cache
    assign do_store   = store_kind && !dec.funct3[2];

    assign rsp_done = issued && (rsp.response == RESP_DONE);
    assign rsp_err  = issued && (rsp.response == RESP_MISALIGNED ||
                                 rsp.response == RESP_ACCESSFAULT ||
                                 rsp.response == RESP_PAGEFAULT);

    assign mem_done = rsp_done;
    assign mem_err  = rsp_err;

    always_comb begin
        req.address    = store_kind ? rs1_data + dec.imm_s : rs1_data + dec.imm_i;
        req.load_type  = dec.funct3;
        req.store_type = dec.funct3[1:0];
        req.store_data = rs2_data;
        // Command held from the first cycle, dropped in the response cycle
        if (rsp_done || rsp_err) begin
            req.cmd = CMD_NONE;
        end else if (do_load) begin
            req.cmd = CMD_LOAD;
        end else if (do_store) begin
            req.cmd = CMD_STORE;
        end else begin
            req.cmd = CMD_NONE;
        end
    end

    always_comb begin
        case (rsp.response)
            RESP_MISALIGNED: err_cause = store_kind ? EXC_STORE_MISALIGNED : EXC_LOAD_MISALIGNED;
            RESP_PAGEFAULT:  err_cause = store_kind ? EXC_STORE_PAGE_FAULT : EXC_LOAD_PAGE_FAULT;
            default:         err_cause = store_kind ? EXC_STORE_ACCESS_FAULT : EXC_LOAD_ACCESS_FAULT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issued <= 1'b0;
        end else if (cache_reset_done) begin
            if (rsp_done || rsp_err) begin
                issued <= 1'b0;
            end else if (do_load || do_store) begin
                issued <= 1'b1;
            end
        end
    end

endmodule

// File: exec_control.sv
`timescale 1ns/1ps

module exec_control (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cache_reset_done,
    input  exec_pkg::fetch_in_t     fin,
    input  exec_pkg::decoded_t      dec,
    input  rv_isa_pkg::xlen_t       rs1_data,
    input  rv_isa_pkg::xlen_t       alu_result,
    input  logic                    alu_illegal,
    input  logic                    br_taken,
    input  logic                    br_illegal,
    input  logic                    mem_done,
    input  logic                    mem_err,
    input  rv_isa_pkg::exc_cause_e  err_cause,
    input  rv_isa_pkg::xlen_t       load_data,
    output exec_pkg::fetch_out_t    fout,
    output exec_pkg::rd_write_t     rd,
    output exec_pkg::exc_report_t   exc
);

    import rv_isa_pkg::*;
    import exec_pkg::*;

    logic    deferred;
    logic    illegal;
    logic    wr_req;
    rd_sel_e rd_sel;
    xlen_t   pc_plus_4;
    xlen_t   wb_data;

    assign pc_plus_4 = fin.pc + PC_STEP;

    always_comb begin
        case (dec.opcode)
            OPCODE_OP,
            OPCODE_OP_IMM: illegal = alu_illegal;
            OPCODE_BRANCH: illegal = br_illegal;
            OPCODE_JALR:   illegal = (dec.funct3 != '0);
            OPCODE_STORE:  illegal = dec.funct3[2];
            OPCODE_JAL,
            OPCODE_LUI,
            OPCODE_AUIPC,
            OPCODE_LOAD:   illegal = 1'b0;
            // SYSTEM, FENCE and unknown opcodes
            default:       illegal = 1'b1;
        endcase
    end

    always_comb begin
        case (rd_sel)
            RD_LOAD:      wb_data = load_data;
            RD_LUI:       wb_data = dec.imm_u;
            RD_AUIPC:     wb_data = fin.pc + dec.imm_u;
            RD_PC_PLUS_4: wb_data = pc_plus_4;
            default:      wb_data = alu_result;
        endcase
    end

    always_comb begin
        fout.ready         = 1'b1;
        fout.exc_start     = 1'b0;
        fout.branch_taken  = 1'b0;
        fout.branch_target = fin.pc + dec.imm_b;
        wr_req    = 1'b0;
        rd_sel    = RD_ALU;
        exc.valid = 1'b0;
        exc.cause = err_cause;
        exc.epc   = fin.pc;

        if (deferred) begin
            // Second cycle of an illegal instruction
            fout.exc_start = 1'b1;
        end else if (illegal) begin
            fout.ready = 1'b0;
            exc.valid  = 1'b1;
            exc.cause  = EXC_ILLEGAL_INSTR;
        end else begin
            case (dec.opcode)
                OPCODE_OP,
                OPCODE_OP_IMM: wr_req = 1'b1;
                OPCODE_LUI: begin
                    wr_req = 1'b1;
                    rd_sel = RD_LUI;
                end
                OPCODE_AUIPC: begin
                    wr_req = 1'b1;
                    rd_sel = RD_AUIPC;
                end
                OPCODE_JAL: begin
                    fout.branch_taken  = 1'b1;
                    fout.branch_target = fin.pc + dec.imm_j;
                    wr_req = 1'b1;
                    rd_sel = RD_PC_PLUS_4;
                end
                OPCODE_JALR: begin
                    fout.branch_taken  = 1'b1;
                    fout.branch_target = rs1_data + dec.imm_i;
                    wr_req = 1'b1;
                    rd_sel = RD_PC_PLUS_4;
                end
                OPCODE_BRANCH: fout.branch_taken = br_taken;
                OPCODE_LOAD,
                OPCODE_STORE: begin
                    // Fetch stalls until the cache answers
                    fout.ready     = mem_done || mem_err;
                    fout.exc_start = mem_err;
                    exc.valid      = mem_err;
                    wr_req = mem_done && (dec.opcode == OPCODE_LOAD);
                    rd_sel = RD_LOAD;
                end
                default: wr_req = 1'b0;
            endcase
        end

        // x0 is never written
        rd.write = wr_req && (dec.rd != '0);
        rd.addr  = dec.rd;
        rd.wdata = wb_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            deferred <= 1'b0;
        end else if (cache_reset_done) begin
            deferred <= !deferred && illegal;
        end
    end

endmodule

// File: exec_top.sv
`timescale 1ns/1ps

module exec_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cache_reset_done,
    input  exec_pkg::fetch_in_t     fin,
    output rv_isa_pkg::reg_addr_t   rs1_addr,
    output rv_isa_pkg::reg_addr_t   rs2_addr,
    input  rv_isa_pkg::xlen_t       rs1_data,
    input  rv_isa_pkg::xlen_t       rs2_data,
    output exec_pkg::cache_req_t    cache_req,
    input  exec_pkg::cache_rsp_t    cache_rsp,
    output exec_pkg::fetch_out_t    fout,
    output exec_pkg::rd_write_t     rd,
    output exec_pkg::exc_report_t   exc
);

    import rv_isa_pkg::*;
    import exec_pkg::*;

    decoded_t   dec;
    xlen_t      alu_result;
    logic       alu_illegal;
    logic       br_taken;
    logic       br_illegal;
    logic       mem_done;
    logic       mem_err;
    exc_cause_e err_cause;

    // Register file reads straight from the instruction fields
    assign rs1_addr = dec.rs1;
    assign rs2_addr = dec.rs2;

    exec_decode u_decode (
        .instr (fin.instr),
        .dec   (dec)
    );

    exec_alu u_alu (
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result),
        .illegal  (alu_illegal)
    );

    exec_branch_cond u_branch_cond (
        .funct3   (dec.funct3),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .taken    (br_taken),
        .illegal  (br_illegal)
    );

    exec_mem_seq u_mem_seq (
        .clk              (clk),
        .rst_n            (rst_n),
        .cache_reset_done (cache_reset_done),
        .dec              (dec),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .req              (cache_req),
        .rsp              (cache_rsp),
        .mem_done         (mem_done),
        .mem_err          (mem_err),
        .err_cause        (err_cause)
    );

    exec_control u_control (
        .clk              (clk),
        .rst_n            (rst_n),
        .cache_reset_done (cache_reset_done),
        .fin              (fin),
        .dec              (dec),
        .rs1_data         (rs1_data),
        .alu_result       (alu_result),
        .alu_illegal      (alu_illegal),
        .br_taken         (br_taken),
        .br_illegal       (br_illegal),
        .mem_done         (mem_done),
        .mem_err          (mem_err),
        .err_cause        (err_cause),
        .load_data        (cache_rsp.load_data),
        .fout             (fout),
        .rd               (rd),
        .exc              (exc)
    );

endmodule

// File: exec_assertions.sv
`timescale 1ns/1ps

module exec_assertions (
    input logic                  clk,
    input logic                  rst_n,
    input exec_pkg::fetch_out_t  fout,
    input exec_pkg::rd_write_t   rd,
    input exec_pkg::cache_req_t  cache_req,
    input exec_pkg::cache_rsp_t  cache_rsp
);

    import exec_pkg::*;

    // x0 stays zero
    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        rd.write |-> (rd.addr != 5'd0))
        else $error("register write to x0");

    exc_start_ready: assert property (@(posedge clk) disable iff (!rst_n)
        fout.exc_start |-> fout.ready)
        else $error("exc_start without ready");

    // Pending command only drops to NONE when the cache answers
    cmd_held: assert property (@(posedge clk) disable iff (!rst_n)
        (cache_req.cmd != CMD_NONE && cache_rsp.response inside {RESP_IDLE, RESP_WAIT})
        |=> ($stable(cache_req) || !(cache_rsp.response inside {RESP_IDLE, RESP_WAIT})))
        else $error("cache command changed before the response");

endmodule

bind exec_top exec_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .fout      (fout),
    .rd        (rd),
    .cache_req (cache_req),
    .cache_rsp (cache_rsp)
);

// File: tb_exec.sv
`timescale 1ns/1ps

module tb_exec;

    import rv_isa_pkg::*;
    import exec_pkg::*;

    localparam int NUM_INSTR  = 3000;
    localparam int MAX_CYCLES = 20;

    logic        clk;
    logic        rst_n;
    logic        cache_reset_done;
    fetch_in_t   fin;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    cache_req_t  cache_req;
    cache_rsp_t  cache_rsp;
    fetch_out_t  fout;
    rd_write_t   rd;
    exc_report_t exc;

    logic [31:0] seed;
    int          rd_errs;
    int          fetch_errs;
    int          exc_errs;
    int          req_errs;
    int          addr_errs;
    logic        timed_out;

    // Reference model results for the instruction in execute
    logic        exp_illegal;
    logic        exp_mem;
    logic        exp_store;
    rd_write_t   exp_rd;
    fetch_out_t  exp_fetch;
    cache_req_t  exp_req;

    exec_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Two LCG steps per call keeping only the upper halves
    function automatic logic [31:0] lcg_next();
        logic [15:0] hi;
        seed = seed * 32'd1664525 + 32'd1013904223;
        hi   = seed[31:16];
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {hi, seed[31:16]};
    endfunction

    function automatic int rand_below(int n);
        return int'(lcg_next() % 32'(n));
    endfunction

    // Weighted opcode mix over random fields
    function automatic logic [31:0] gen_instr();
        logic [31:0] w;
        int          pick;
        w    = lcg_next();
        pick = rand_below(20);
        case (pick) inside
            [0:4]:   w[6:0] = OPCODE_OP;
            [5:7]:   w[6:0] = OPCODE_OP_IMM;
            8:       w[6:0] = OPCODE_LUI;
            9:       w[6:0] = OPCODE_AUIPC;
            10:      w[6:0] = OPCODE_JAL;
            11:      w[6:0] = OPCODE_JALR;
            [12:13]: w[6:0] = OPCODE_BRANCH;
            [14:15]: w[6:0] = OPCODE_LOAD;
            [16:17]: w[6:0] = OPCODE_STORE;
            default: begin
                case (rand_below(3))
                    0:       w[6:0] = OPCODE_SYSTEM;
                    1:       w[6:0] = OPCODE_FENCE;
                    default: w[6:0] = 7'h7f;
                endcase
            end
        endcase
        // Mostly legal funct7 and JALR funct3 and sometimes x0 as destination
        if (pick <= 7 && rand_below(4) != 0) begin
            w[31:25] = rand_below(2) ? F7_ALT : F7_BASE;
        end
        if (pick == 11 && rand_below(4) != 0) begin
            w[14:12] = 3'b000;
        end
        if (rand_below(8) == 0) begin
            w[11:7] = 5'd0;
        end
        return w;
    endfunction

    function automatic xlen_t alu_model(funct3_t f3, logic sub, logic arith,
                                        xlen_t a, xlen_t b, logic [4:0] sh);
        case (f3)
            3'd0:    return sub ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return arith ? xlen_t'($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic exc_cause_e expected_cause(cache_resp_e r, logic store);
        case (r)
            RESP_MISALIGNED:  return store ? EXC_STORE_MISALIGNED : EXC_LOAD_MISALIGNED;
            RESP_ACCESSFAULT: return store ? EXC_STORE_ACCESS_FAULT : EXC_LOAD_ACCESS_FAULT;
            default:          return store ? EXC_STORE_PAGE_FAULT : EXC_LOAD_PAGE_FAULT;
        endcase
    endfunction

    task automatic predict();
        logic [31:0] ins;
        logic [6:0]  op;
        logic [6:0]  f7;
        funct3_t     f3;
        xlen_t       a;
        xlen_t       b;
        xlen_t       imm_i;
        xlen_t       imm_s;
        xlen_t       imm_b;
        xlen_t       imm_u;
        xlen_t       imm_j;
        xlen_t       val;
        logic        wr;
        ins   = fin.instr;
        op    = ins[6:0];
        f3    = ins[14:12];
        f7    = ins[31:25];
        a     = rs1_data;
        b     = rs2_data;
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'h000};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        val   = '0;
        wr    = 1'b0;
        exp_illegal = 1'b0;
        exp_mem     = 1'b0;
        exp_store   = 1'b0;
        exp_fetch   = '0;
        exp_fetch.ready = 1'b1;
        exp_req     = '0;
        case (op)
            OPCODE_OP: begin
                exp_illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                val = alu_model(f3, f7[5], f7[5], a, b, b[4:0]);
                wr  = 1'b1;
            end
            OPCODE_OP_IMM: begin
                exp_illegal = (f3 == 3'd1 && f7 != 7'h00) ||
                              (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
                val = alu_model(f3, 1'b0, f7[5], a, imm_i, ins[24:20]);
                wr  = 1'b1;
            end
            OPCODE_LUI: begin
                val = imm_u;
                wr  = 1'b1;
            end
            OPCODE_AUIPC: begin
                val = fin.pc + imm_u;
                wr  = 1'b1;
            end
            OPCODE_JAL, OPCODE_JALR: begin
                exp_illegal = (op == OPCODE_JALR) && (f3 != 3'd0);
                exp_fetch.branch_taken  = 1'b1;
                exp_fetch.branch_target = (op == OPCODE_JAL) ? fin.pc + imm_j : a + imm_i;
                val = fin.pc + 32'd4;
                wr  = 1'b1;
            end
            OPCODE_BRANCH: begin
                exp_fetch.branch_target = fin.pc + imm_b;
                case (f3)
                    3'd0:    exp_fetch.branch_taken = (a == b);
                    3'd1:    exp_fetch.branch_taken = (a != b);
                    3'd4:    exp_fetch.branch_taken = ($signed(a) < $signed(b));
                    3'd5:    exp_fetch.branch_taken = ($signed(a) >= $signed(b));
                    3'd6:    exp_fetch.branch_taken = (a < b);
                    3'd7:    exp_fetch.branch_taken = (a >= b);
                    default: exp_illegal = 1'b1;
                endcase
            end
            OPCODE_LOAD: begin
                exp_mem             = 1'b1;
                exp_req.cmd         = CMD_LOAD;
                exp_req.address     = a + imm_i;
                exp_req.load_type   = f3;
            end
            OPCODE_STORE: begin
                exp_illegal         = f3[2];
                exp_mem             = !f3[2];
                exp_store           = 1'b1;
                exp_req.cmd         = CMD_STORE;
                exp_req.address     = a + imm_s;
                exp_req.store_type  = f3[1:0];
                exp_req.store_data  = b;
            end
            default: exp_illegal = 1'b1;
        endcase
        exp_rd.write = wr && (ins[11:7] != 5'd0);
        exp_rd.addr  = ins[11:7];
        exp_rd.wdata = val;
    endtask

    task automatic check_rd(input rd_write_t want, input rd_write_t got);
        if (got.write !== want.write ||
            (want.write && (got.addr !== want.addr || got.wdata !== want.wdata))) begin
            rd_errs++;
            $display("error at %0t: rd write %b x%0d=%h, expected %b x%0d=%h", $time,
                     got.write, got.addr, got.wdata, want.write, want.addr, want.wdata);
        end
    endtask

    task automatic check_fetch(input fetch_out_t want, input fetch_out_t got);
        if (got.ready !== want.ready || got.exc_start !== want.exc_start ||
            got.branch_taken !== want.branch_taken ||
            (want.branch_taken && got.branch_target !== want.branch_target)) begin
            fetch_errs++;
            $display("error at %0t: fetch out %b%b%b %h, expected %b%b%b %h", $time,
                     got.ready, got.exc_start, got.branch_taken, got.branch_target,
                     want.ready, want.exc_start, want.branch_taken, want.branch_target);
        end
    endtask

    task automatic check_exc(input exc_report_t want, input exc_report_t got);
        if (got.valid !== want.valid ||
            (want.valid && (got.cause !== want.cause || got.epc !== want.epc))) begin
            exc_errs++;
            $display("error at %0t: exception %b cause %0d epc %h, expected %b %0d %h",
                     $time, got.valid, got.cause, got.epc, want.valid, want.cause, want.epc);
        end
    endtask

    task automatic check_req(input cache_req_t want, input cache_req_t got);
        logic bad;
        bad = (got.cmd !== want.cmd);
        if (want.cmd != CMD_NONE && got.address !== want.address) begin
            bad = 1'b1;
        end
        if (want.cmd == CMD_LOAD && got.load_type !== want.load_type) begin
            bad = 1'b1;
        end
        if (want.cmd == CMD_STORE &&
            (got.store_type !== want.store_type || got.store_data !== want.store_data)) begin
            bad = 1'b1;
        end
        if (bad) begin
            req_errs++;
            $display("error at %0t: cache cmd %0d addr %h, expected %0d addr %h", $time,
                     got.cmd, got.address, want.cmd, want.address);
        end
    endtask

    task automatic check_reg_addr(input reg_addr_t want, input reg_addr_t got);
        if (got !== want) begin
            addr_errs++;
            $display("error at %0t: register read address x%0d, expected x%0d", $time,
                     got, want);
        end
    endtask

    // Drives one instruction and checks every cycle until it retires
    task automatic run_instr();
        fetch_out_t  f_exp;
        exc_report_t e_exp;
        rd_write_t   r_exp;
        cache_req_t  q_exp;
        xlen_t       pc_raw;
        int          cycles;
        logic        finished;
        fin.instr = gen_instr();
        pc_raw    = lcg_next();
        fin.pc    = {pc_raw[31:2], 2'b00};
        rs1_data  = lcg_next();
        rs2_data  = (rand_below(8) == 0) ? rs1_data : lcg_next();
        predict();
        cycles   = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            f_exp     = '0;
            e_exp     = '0;
            r_exp     = '0;
            q_exp     = '0;
            e_exp.epc = fin.pc;
            if (exp_illegal) begin
                if (cycles == 0) begin
                    e_exp.valid = 1'b1;
                    e_exp.cause = EXC_ILLEGAL_INSTR;
                end else begin
                    f_exp.ready     = 1'b1;
                    f_exp.exc_start = 1'b1;
                end
            end else if (exp_mem) begin
                if (cache_rsp.response == RESP_DONE) begin
                    f_exp.ready = 1'b1;
                    r_exp.write = !exp_store && (fin.instr[11:7] != 5'd0);
                    r_exp.addr  = fin.instr[11:7];
                    r_exp.wdata = cache_rsp.load_data;
                end else if (cache_rsp.response == RESP_MISALIGNED ||
                             cache_rsp.response == RESP_ACCESSFAULT ||
                             cache_rsp.response == RESP_PAGEFAULT) begin
                    f_exp.ready     = 1'b1;
                    f_exp.exc_start = 1'b1;
                    e_exp.valid     = 1'b1;
                    e_exp.cause     = expected_cause(cache_rsp.response, exp_store);
                end else begin
                    q_exp = exp_req;
                end
            end else begin
                f_exp = exp_fetch;
                r_exp = exp_rd;
            end
            check_fetch(f_exp, fout);
            check_rd(r_exp, rd);
            check_exc(e_exp, exc);
            check_req(q_exp, cache_req);
            check_reg_addr(fin.instr[19:15], rs1_addr);
            check_reg_addr(fin.instr[24:20], rs2_addr);
            if (fout.ready) begin
                finished = 1'b1;
            end else begin
                cycles++;
                if (cycles > MAX_CYCLES) begin
                    $display("Timeout: ready stayed low for the instruction at pc %h", fin.pc);
                    timed_out = 1'b1;
                    finished  = 1'b1;
                end
            end
            @(posedge clk);
            #1;
        end
    endtask

    // Cache side answers each command after a few WAIT cycles
    initial begin : cache_responder
        int waits;
        int code;
        forever begin
            @(posedge clk);
            if (rst_n && cache_req.cmd != CMD_NONE) begin
                waits = rand_below(5);
                repeat (waits) begin
                    #1 cache_rsp.response = RESP_WAIT;
                    @(posedge clk);
                end
                #1;
                code = rand_below(16);
                cache_rsp.load_data = lcg_next();
                case (code)
                    0:       cache_rsp.response = RESP_MISALIGNED;
                    1:       cache_rsp.response = RESP_ACCESSFAULT;
                    2:       cache_rsp.response = RESP_PAGEFAULT;
                    default: cache_rsp.response = RESP_DONE;
                endcase
                @(posedge clk);
                #1 cache_rsp.response = RESP_IDLE;
            end
        end
    end

    initial begin : main
        int n;
        seed             = 32'd64615;
        rst_n            = 1'b0;
        cache_reset_done = 1'b0;
        fin              = '0;
        rs1_data         = '0;
        rs2_data         = '0;
        cache_rsp        = '0;
        rd_errs          = 0;
        fetch_errs       = 0;
        exc_errs         = 0;
        req_errs         = 0;
        addr_errs        = 0;
        timed_out        = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n            = 1'b1;
        cache_reset_done = 1'b1;
        for (n = 0; n < NUM_INSTR && !timed_out; n++) begin
            run_instr();
        end
        $display("Error counts: rd %0d, fetch %0d, exc %0d, req %0d, addr %0d",
                 rd_errs, fetch_errs, exc_errs, req_errs, addr_errs);
        if (!timed_out &&
            rd_errs + fetch_errs + exc_errs + req_errs + addr_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: all.f
rv_isa_pkg.sv
exec_pkg.sv
exec_decode.sv
exec_alu.sv
exec_branch_cond.sv
exec_mem_seq.sv
exec_control.sv
exec_top.sv
exec_assertions.sv
tb_exec.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_exec || exit 1
out=$(./obj_dir/Vtb_exec)
echo "$out"
echo "$out" | grep -qx "Done: no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
